/* rtl/predecPkg.sv */
`default_nettype none

package predecPkg;

  localparam int CLS_WIDTH = 9;

  // class bit positions.
  localparam int CLS_ALU = 0;
  localparam int CLS_SHIFT = 1;
  localparam int CLS_MUL = 2;
  localparam int CLS_LOAD = 3;
  localparam int CLS_STORE = 4;
  localparam int CLS_JUMP = 5;
  localparam int CLS_INDIR = 6;
  localparam int CLS_SYS = 7;
  localparam int CLS_ILLEGAL = 8;

  typedef logic [CLS_WIDTH-1:0] instrClassT; // more than one bit may be set.

  typedef logic [1:0] lnkSizeT; // link offset in halfwords, 0 is no link.

  // instr, compressed, class, lnk, ret, lnkSize.
  localparam int ENTRY_WIDTH = 32 + 1 + CLS_WIDTH + 1 + 1 + $bits(lnkSizeT);

  typedef enum logic [1:0] {
    UNIT_ALU  = 2'd0,
    UNIT_MEM  = 2'd1,
    UNIT_BR   = 2'd2,
    UNIT_TRAP = 2'd3
  } unitSelT;

endpackage

`default_nettype wire

/* rtl/rvPredecoder.sv */
`default_nettype none

module rvPredecoder (
  input  logic [31:0]           instr,
  output predecPkg::instrClassT instrClass,
  output logic                  isCompressed,
  output logic                  isLnk,
  output logic                  isRet,
  output predecPkg::lnkSizeT    lnkSize
);
  import predecPkg::*;

  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_OP = 7'b0110011;
  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_JAL = 7'b1101111;
  localparam logic [6:0] OPC_JALR = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic [6:0] opcode;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic       isShiftF3;
  logic       rdIsLink;
  logic       rs1IsLink;
  logic [4:0] cRd;
  logic [4:0] cRs2;

  assign opcode = instr[6:0];
  assign rd = instr[11:7];
  assign rs1 = instr[19:15];
  assign isShiftF3 = instr[13:12] == 2'b01; // funct3 001 or 101.
  assign rdIsLink = rd == 5'd1 || rd == 5'd5;
  assign rs1IsLink = rs1 == 5'd1 || rs1 == 5'd5;
  assign cRd = instr[11:7]; // also rs1 of c.jr and c.jalr.
  assign cRs2 = instr[6:2];

  assign isCompressed = instr[1:0] != 2'b11;

  always_comb begin
    instrClass = '0;
    isLnk = 1'b0;
    isRet = 1'b0;
    if (!isCompressed) begin
      case (opcode)
        OPC_LOAD: instrClass[CLS_LOAD] = 1'b1;
        OPC_STORE: instrClass[CLS_STORE] = 1'b1;
        OPC_OPIMM: instrClass[isShiftF3 ? CLS_SHIFT : CLS_ALU] = 1'b1;
        OPC_OP: begin
          if (instr[31:25] == 7'b0000001) begin
            instrClass[CLS_MUL] = 1'b1;
          end else begin
            instrClass[isShiftF3 ? CLS_SHIFT : CLS_ALU] = 1'b1;
          end
        end
        OPC_LUI, OPC_AUIPC: instrClass[CLS_ALU] = 1'b1;
        OPC_JAL: begin
          instrClass[CLS_JUMP] = 1'b1;
          instrClass[CLS_ALU] = rd != 5'd0; // writes a register.
          isLnk = rdIsLink;
        end
        OPC_JALR: begin
          instrClass[CLS_JUMP] = 1'b1;
          instrClass[CLS_INDIR] = 1'b1;
          isLnk = rdIsLink;
          isRet = rd == 5'd0 && rs1IsLink;
        end
        OPC_BRANCH: instrClass[CLS_JUMP] = 1'b1;
        OPC_SYSTEM: instrClass[CLS_SYS] = 1'b1;
        default: instrClass[CLS_ILLEGAL] = 1'b1;
      endcase
    end else begin
      case ({instr[1:0], instr[15:13]})
        5'b00_000: instrClass[instr[12:5] != 8'd0 ? CLS_ALU : CLS_ILLEGAL] = 1'b1; // c.addi4spn.
        5'b00_010, 5'b10_010: instrClass[CLS_LOAD] = 1'b1;
        5'b00_110, 5'b10_110: instrClass[CLS_STORE] = 1'b1;
        5'b01_000, 5'b01_010, 5'b01_011: instrClass[CLS_ALU] = 1'b1;
        5'b01_001: begin
          instrClass[CLS_JUMP] = 1'b1; // c.jal.
          isLnk = 1'b1;
        end
        5'b01_101, 5'b01_110, 5'b01_111: instrClass[CLS_JUMP] = 1'b1;
        5'b01_100: begin
          case (instr[11:10])
            2'b00, 2'b01: instrClass[CLS_SHIFT] = 1'b1;
            2'b10: instrClass[CLS_ALU] = 1'b1;
            default: instrClass[instr[12] ? CLS_ILLEGAL : CLS_ALU] = 1'b1; // rv64 ops illegal.
          endcase
        end
        5'b10_000: instrClass[CLS_SHIFT] = 1'b1;
        5'b10_100: begin
          if (cRs2 != 5'd0) begin
            instrClass[CLS_ALU] = 1'b1; // c.mv, c.add.
          end else if (cRd == 5'd0) begin
            instrClass[CLS_ILLEGAL] = 1'b1; // reserved and c.ebreak.
          end else begin
            instrClass[CLS_JUMP] = 1'b1;
            instrClass[CLS_INDIR] = 1'b1;
            isLnk = instr[12];
            isRet = !instr[12] && (cRd == 5'd1 || cRd == 5'd5);
          end
        end
        default: instrClass[CLS_ILLEGAL] = 1'b1;
      endcase
    end
  end

  assign lnkSize = !isLnk ? 2'd0 : (isCompressed ? 2'd1 : 2'd2);

endmodule

`default_nettype wire

/* rtl/instrAligner.sv */
`default_nettype none

module instrAligner (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [31:0]           fetchWord,
  input  logic                  fetchValid,
  input  logic                  full,
  output logic                  fetchHold,
  output logic                  push,
  output logic [31:0]           pushInstr,
  output logic                  pushCompressed,
  output predecPkg::instrClassT pushClass,
  output logic                  pushLnk,
  output logic                  pushRet,
  output predecPkg::lnkSizeT    pushLnkSize
);

  logic [15:0] hwBuf [3]; // oldest halfword at index 0.
  logic [15:0] hwNext [3];
  logic [1:0]  hwCnt;
  logic [1:0]  used;
  logic [1:0]  remCnt;
  logic        complete;
  logic        accept;

  rvPredecoder predecoder (
    .instr        ({hwBuf[1], hwBuf[0]}),
    .instrClass   (pushClass),
    .isCompressed (pushCompressed),
    .isLnk        (pushLnk),
    .isRet        (pushRet),
    .lnkSize      (pushLnkSize)
  );

  assign complete = pushCompressed ? hwCnt != 2'd0 : hwCnt >= 2'd2;
  assign push = complete && !full;
  assign used = !push ? 2'd0 : (pushCompressed ? 2'd1 : 2'd2);
  assign remCnt = hwCnt - used;

  // room for a full word only when at most one halfword stays.
  assign fetchHold = remCnt >= 2'd2;
  assign accept = fetchValid && !fetchHold;

  assign pushInstr = pushCompressed ? {16'd0, hwBuf[0]} : {hwBuf[1], hwBuf[0]};

  always_comb begin
    hwNext = hwBuf;
    case (used)
      2'd1: begin
        hwNext[0] = hwBuf[1];
        hwNext[1] = hwBuf[2];
      end
      2'd2: hwNext[0] = hwBuf[2];
      default: ;
    endcase
    if (accept) begin
      hwNext[remCnt] = fetchWord[15:0]; // low half first.
      hwNext[remCnt + 2'd1] = fetchWord[31:16];
    end
  end

  always_ff @(posedge clk) begin
    hwBuf <= hwNext;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      hwCnt <= 2'd0;
    end else begin
      hwCnt <= remCnt + (accept ? 2'd2 : 2'd0);
    end
  end

endmodule

`default_nettype wire

/* rtl/predecQueue.sv */
`default_nettype none

module predecQueue #(
  parameter int DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              push,
  input  logic [predecPkg::ENTRY_WIDTH-1:0] pushEntry,
  input  logic                              pop,
  output logic [predecPkg::ENTRY_WIDTH-1:0] headEntry,
  output logic                              full,
  output logic                              empty
);
  import predecPkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [ENTRY_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0]       wrPtr;
  logic [PTR_W-1:0]       rdPtr;
  logic [CNT_W-1:0]       count;
  logic                   doPush;
  logic                   doPop;

  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign full = count == CNT_W'(DEPTH);
  assign empty = count == '0;
  assign doPop = pop && !empty;
  assign doPush = push && (!full || doPop); // a pop frees the slot.

  assign headEntry = mem[rdPtr]; // fall through.

  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= pushEntry;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doPop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      count <= count + CNT_W'(doPush) - CNT_W'(doPop);
    end
  end

endmodule

`default_nettype wire

/* rtl/dispatchSteer.sv */
`default_nettype none

module dispatchSteer (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              empty,
  input  logic [predecPkg::ENTRY_WIDTH-1:0] headEntry,
  input  logic                              aluBusy,
  input  logic                              memBusy,
  input  logic                              brBusy,
  output logic                              pop,
  output logic                              aluIssue,
  output logic                              memIssue,
  output logic                              brIssue,
  output logic                              trapIssue,
  output logic [31:0]                       issueInstr,
  output logic                              issueCompressed,
  output predecPkg::instrClassT             issueClass,
  output logic                              issueLnk,
  output logic                              issueRet,
  output predecPkg::lnkSizeT                issueLnkSize
);
  import predecPkg::*;

  logic [31:0] headInstr;
  logic        headCompressed;
  instrClassT  headClass;
  logic        headLnk;
  logic        headRet;
  lnkSizeT     headLnkSize;
  unitSelT     unitSel;
  logic        unitFree;

  assign {headInstr, headCompressed, headClass, headLnk, headRet, headLnkSize} = headEntry;

  always_comb begin
    if (headClass[CLS_JUMP] || headClass[CLS_SYS])
      unitSel = UNIT_BR;
    else if (headClass[CLS_LOAD] || headClass[CLS_STORE])
      unitSel = UNIT_MEM;
    else if (headClass[CLS_ALU] || headClass[CLS_SHIFT] || headClass[CLS_MUL])
      unitSel = UNIT_ALU;
    else
      unitSel = UNIT_TRAP;
  end

  always_comb begin
    case (unitSel)
      UNIT_ALU: unitFree = !aluBusy;
      UNIT_MEM: unitFree = !memBusy;
      UNIT_BR: unitFree = !brBusy;
      default: unitFree = 1'b1; // trap never stalls.
    endcase
  end

  assign pop = !empty && unitFree; // a busy head stalls everything behind it.

  always_ff @(posedge clk) begin
    if (!rstN) begin
      aluIssue <= 1'b0;
      memIssue <= 1'b0;
      brIssue <= 1'b0;
      trapIssue <= 1'b0;
    end else begin
      aluIssue <= pop && unitSel == UNIT_ALU;
      memIssue <= pop && unitSel == UNIT_MEM;
      brIssue <= pop && unitSel == UNIT_BR;
      trapIssue <= pop && unitSel == UNIT_TRAP;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      issueInstr <= headInstr;
      issueCompressed <= headCompressed;
      issueClass <= headClass;
      issueLnk <= headLnk;
      issueRet <= headRet;
      issueLnkSize <= headLnkSize;
    end
  end

endmodule

`default_nettype wire

/* rtl/predecTop.sv */
`default_nettype none

module predecTop #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [31:0]           fetchWord,
  input  logic                  fetchValid,
  output logic                  fetchHold,
  input  logic                  aluBusy,
  input  logic                  memBusy,
  input  logic                  brBusy,
  output logic                  aluIssue,
  output logic                  memIssue,
  output logic                  brIssue,
  output logic                  trapIssue,
  output logic [31:0]           issueInstr,
  output logic                  issueCompressed,
  output predecPkg::instrClassT issueClass,
  output logic                  issueLnk,
  output logic                  issueRet,
  output predecPkg::lnkSizeT    issueLnkSize
);
  import predecPkg::*;

  logic                   push;
  logic [31:0]            pushInstr;
  logic                   pushCompressed;
  instrClassT             pushClass;
  logic                   pushLnk;
  logic                   pushRet;
  lnkSizeT                pushLnkSize;
  logic [ENTRY_WIDTH-1:0] pushEntry;
  logic [ENTRY_WIDTH-1:0] headEntry;
  logic                   full;
  logic                   empty;
  logic                   pop;

  // same field order is unpacked in dispatchSteer.
  assign pushEntry = {pushInstr, pushCompressed, pushClass, pushLnk, pushRet, pushLnkSize};

  instrAligner aligner (
    .clk            (clk),
    .rstN           (rstN),
    .fetchWord      (fetchWord),
    .fetchValid     (fetchValid),
    .full           (full),
    .fetchHold      (fetchHold),
    .push           (push),
    .pushInstr      (pushInstr),
    .pushCompressed (pushCompressed),
    .pushClass      (pushClass),
    .pushLnk        (pushLnk),
    .pushRet        (pushRet),
    .pushLnkSize    (pushLnkSize)
  );

  predecQueue #(
    .DEPTH (QUEUE_DEPTH)
  ) queue (
    .clk       (clk),
    .rstN      (rstN),
    .push      (push),
    .pushEntry (pushEntry),
    .pop       (pop),
    .headEntry (headEntry),
    .full      (full),
    .empty     (empty)
  );

  dispatchSteer steer (
    .clk             (clk),
    .rstN            (rstN),
    .empty           (empty),
    .headEntry       (headEntry),
    .aluBusy         (aluBusy),
    .memBusy         (memBusy),
    .brBusy          (brBusy),
    .pop             (pop),
    .aluIssue        (aluIssue),
    .memIssue        (memIssue),
    .brIssue         (brIssue),
    .trapIssue       (trapIssue),
    .issueInstr      (issueInstr),
    .issueCompressed (issueCompressed),
    .issueClass      (issueClass),
    .issueLnk        (issueLnk),
    .issueRet        (issueRet),
    .issueLnkSize    (issueLnkSize)
  );

endmodule

`default_nettype wire

/* include/rvClassModel.svh */
`ifndef RV_CLASS_MODEL_SVH
`define RV_CLASS_MODEL_SVH

function automatic logic modelIsLinkReg(input logic [4:0] r);
  return r == 5'd1 || r == 5'd5;
endfunction

function automatic predecPkg::instrClassT modelClass(input logic [31:0] ins);
  predecPkg::instrClassT cls;
  logic                  shiftF3;
  cls = '0;
  shiftF3 = ins[14:12] == 3'b001 || ins[14:12] == 3'b101;
  if (ins[1:0] == 2'b11) begin
    case (ins[6:2])
      5'b00000: cls[predecPkg::CLS_LOAD] = 1'b1;
      5'b01000: cls[predecPkg::CLS_STORE] = 1'b1;
      5'b00100: cls[shiftF3 ? predecPkg::CLS_SHIFT : predecPkg::CLS_ALU] = 1'b1;
      5'b01100: begin
        if (ins[31:25] == 7'b0000001)
          cls[predecPkg::CLS_MUL] = 1'b1;
        else
          cls[shiftF3 ? predecPkg::CLS_SHIFT : predecPkg::CLS_ALU] = 1'b1;
      end
      5'b01101, 5'b00101: cls[predecPkg::CLS_ALU] = 1'b1;
      5'b11011: begin
        cls[predecPkg::CLS_JUMP] = 1'b1;
        cls[predecPkg::CLS_ALU] = ins[11:7] != 5'd0;
      end
      5'b11001: begin
        cls[predecPkg::CLS_JUMP] = 1'b1;
        cls[predecPkg::CLS_INDIR] = 1'b1;
      end
      5'b11000: cls[predecPkg::CLS_JUMP] = 1'b1;
      5'b11100: cls[predecPkg::CLS_SYS] = 1'b1;
      default: cls[predecPkg::CLS_ILLEGAL] = 1'b1;
    endcase
  end else begin
    case ({ins[1:0], ins[15:13]})
      5'b00_000: cls[ins[12:5] == 8'd0 ? predecPkg::CLS_ILLEGAL : predecPkg::CLS_ALU] = 1'b1;
      5'b00_010, 5'b10_010: cls[predecPkg::CLS_LOAD] = 1'b1;
      5'b00_110, 5'b10_110: cls[predecPkg::CLS_STORE] = 1'b1;
      5'b01_001, 5'b01_101, 5'b01_110, 5'b01_111: cls[predecPkg::CLS_JUMP] = 1'b1;
      5'b01_000, 5'b01_010, 5'b01_011: cls[predecPkg::CLS_ALU] = 1'b1;
      5'b10_000: cls[predecPkg::CLS_SHIFT] = 1'b1;
      5'b01_100: begin
        if (ins[11:10] == 2'b11 && ins[12])
          cls[predecPkg::CLS_ILLEGAL] = 1'b1;
        else
          cls[ins[11] ? predecPkg::CLS_ALU : predecPkg::CLS_SHIFT] = 1'b1;
      end
      5'b10_100: begin
        if (ins[6:2] != 5'd0) begin
          cls[predecPkg::CLS_ALU] = 1'b1;
        end else if (ins[11:7] == 5'd0) begin
          cls[predecPkg::CLS_ILLEGAL] = 1'b1;
        end else begin
          cls[predecPkg::CLS_JUMP] = 1'b1;
          cls[predecPkg::CLS_INDIR] = 1'b1;
        end
      end
      default: cls[predecPkg::CLS_ILLEGAL] = 1'b1;
    endcase
  end
  return cls;
endfunction

function automatic logic modelLnk(input logic [31:0] ins);
  if (ins[1:0] == 2'b11)
    return (ins[6:0] == 7'b1101111 || ins[6:0] == 7'b1100111) && modelIsLinkReg(ins[11:7]);
  return {ins[1:0], ins[15:13]} == 5'b01_001 ||
         ({ins[1:0], ins[15:12]} == 6'b10_1001 && ins[6:2] == 5'd0 && ins[11:7] != 5'd0);
endfunction

function automatic logic modelRet(input logic [31:0] ins);
  if (ins[1:0] == 2'b11)
    return ins[6:0] == 7'b1100111 && ins[11:7] == 5'd0 && modelIsLinkReg(ins[19:15]);
  return {ins[1:0], ins[15:12]} == 6'b10_1000 && ins[6:2] == 5'd0 && modelIsLinkReg(ins[11:7]);
endfunction

function automatic predecPkg::lnkSizeT modelLnkSize(input logic [31:0] ins);
  if (!modelLnk(ins))
    return 2'd0;
  return (ins[1:0] == 2'b11) ? 2'd2 : 2'd1;
endfunction

function automatic predecPkg::unitSelT modelUnit(input predecPkg::instrClassT cls);
  if (cls[predecPkg::CLS_JUMP] || cls[predecPkg::CLS_SYS])
    return predecPkg::UNIT_BR;
  if (cls[predecPkg::CLS_LOAD] || cls[predecPkg::CLS_STORE])
    return predecPkg::UNIT_MEM;
  if (cls[predecPkg::CLS_ALU] || cls[predecPkg::CLS_SHIFT] || cls[predecPkg::CLS_MUL])
    return predecPkg::UNIT_ALU;
  return predecPkg::UNIT_TRAP;
endfunction

`endif

/* tests/predecTb.sv */
`default_nettype none

module predecTb;
  import predecPkg::*;

  logic        clk;
  logic        rstN;
  logic [31:0] fetchWord;
  logic        fetchValid;
  logic        fetchHold;
  logic        aluBusy;
  logic        memBusy;
  logic        brBusy;
  logic        aluIssue;
  logic        memIssue;
  logic        brIssue;
  logic        trapIssue;
  logic [31:0] issueInstr;
  logic        issueCompressed;
  instrClassT  issueClass;
  logic        issueLnk;
  logic        issueRet;
  lnkSizeT     issueLnkSize;
  logic [3:0]  strobes;

  logic [31:0] instrTable [51];
  logic [31:0] expected [$];
  logic [15:0] halfwords [$];
  logic [31:0] words [$];
  logic [31:0] expIns;
  instrClassT  expCls;
  logic [2:0]  lastBusy = 3'b000;
  logic [2:0]  busy;
  logic        taken = 1'b0;
  logic        fetchSeen = 1'b0;
  logic        sawHold = 1'b0;
  logic        sawFull = 1'b0;
  int          wordIdx = 0;
  int          stretch = 0;
  int          issued = 0;
  int          cycleCount = 0;
  int          cycleLimit = 0;

  `include "rvClassModel.svh"

  predecTop #(
    .QUEUE_DEPTH (4)
  ) DUT (
    .clk             (clk),
    .rstN            (rstN),
    .fetchWord       (fetchWord),
    .fetchValid      (fetchValid),
    .fetchHold       (fetchHold),
    .aluBusy         (aluBusy),
    .memBusy         (memBusy),
    .brBusy          (brBusy),
    .aluIssue        (aluIssue),
    .memIssue        (memIssue),
    .brIssue         (brIssue),
    .trapIssue       (trapIssue),
    .issueInstr      (issueInstr),
    .issueCompressed (issueCompressed),
    .issueClass      (issueClass),
    .issueLnk        (issueLnk),
    .issueRet        (issueRet),
    .issueLnkSize    (issueLnkSize)
  );

  assign strobes = {trapIssue, brIssue, memIssue, aluIssue}; // bit index is the unit code.

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("Error %s (issue %0d): expected %h, actual %h", name, issued, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic addInstr(input logic [31:0] ins);
    expected.push_back(ins);
    halfwords.push_back(ins[15:0]);
    if (ins[1:0] == 2'b11) begin
      halfwords.push_back(ins[31:16]);
    end
  endtask

  task automatic buildStream();
    int pick;
    // 16 and 32 bit entries alternate, so 32-bit ones straddle words.
    instrTable = '{
      32'h0040, 32'h00012083, 32'h4188, 32'h00112023, 32'hc188, 32'h0000,
      32'h00100093, 32'h4082, 32'h00109093, 32'hc006, 32'h4010d093, 32'h0085,
      32'h003100b3, 32'h2001, 32'h003110b3, 32'h4085, 32'h023100b3, 32'h6085,
      32'h000010b7, 32'h8005, 32'h00001097, 32'h8405, 32'h008000ef, 32'h8805,
      32'h0080006f, 32'h8c05, 32'h008002ef, 32'h9c05, 32'h00008067, 32'ha001,
      32'h000100e7, 32'hc001, 32'h00028067, 32'he001, 32'h00000463, 32'h0086,
      32'h00000073, 32'h8082, 32'h0000007f, 32'h8282, 32'h8102, 32'h9082,
      32'h808a, 32'h908a, 32'h9002, 32'h2002, 32'hffffffff, 32'h8c25,
      32'h8c45, 32'h8c65, 32'h6105
    };
    foreach (instrTable[i]) begin
      addInstr(instrTable[i]);
    end
    for (int i = 0; i < 40; i++) begin
      pick = int'($urandom % 51);
      addInstr(instrTable[pick]);
    end
    if (halfwords.size() % 2 != 0) begin
      addInstr(32'h0001); // c.nop fills the last word.
    end
    for (int i = 0; i < halfwords.size(); i += 2) begin
      words.push_back({halfwords[i+1], halfwords[i]});
    end
  endtask

  task automatic driveBusy();
    if (stretch == 0) begin
      if ($urandom % 5 == 0) begin
        busy = 3'b111; // long stall to fill the queue.
        stretch = 24;
      end else begin
        busy = 3'($urandom) & 3'($urandom);
        stretch = 1 + int'($urandom % 3);
      end
    end
    stretch--;
    {brBusy, memBusy, aluBusy} = busy;
  endtask

  always @(negedge clk) begin
    if (rstN) begin
      cycleCount++;
      assert (cycleCount < cycleLimit) else begin
        $display("run timed out after %0d cycles, %0d issues missing", cycleCount,
                 expected.size());
        $display("*** TEST FAILED ***");
        $fatal(1);
      end
      assert ($onehot0(strobes)) else begin
        $display("more than one issue strobe is high");
        $display("*** TEST FAILED ***");
        $fatal(1);
      end
      assert (fetchSeen || (strobes == 4'b0000 && !fetchHold)) else begin
        $display("strobe or fetchHold high before the first fetch");
        $display("*** TEST FAILED ***");
        $fatal(1);
      end
      assert ((strobes[2:0] & lastBusy) == 3'b000) else begin
        $display("issue strobe for a unit that was busy at the pop");
        $display("*** TEST FAILED ***");
        $fatal(1);
      end
      if (strobes != 4'b0000) begin
        assert (expected.size() != 0) else begin
          $display("issue strobe with no instruction left to issue");
          $display("*** TEST FAILED ***");
          $fatal(1);
        end
        expIns = expected.pop_front();
        expCls = modelClass(expIns);
        checkValue("instr", expIns, issueInstr);
        checkValue("compressed", 32'(expIns[1:0] != 2'b11), 32'(issueCompressed));
        checkValue("class", 32'(expCls), 32'(issueClass));
        checkValue("link", 32'(modelLnk(expIns)), 32'(issueLnk));
        checkValue("return", 32'(modelRet(expIns)), 32'(issueRet));
        checkValue("link size", 32'(modelLnkSize(expIns)), 32'(issueLnkSize));
        checkValue("unit strobe", 32'(4'b0001 << modelUnit(expCls)), 32'(strobes));
        issued++;
      end
      sawHold = sawHold | (fetchHold & DUT.full); // hold while the queue pushes back.
      sawFull = sawFull | DUT.full;
    end
    taken = rstN && fetchValid && !fetchHold; // word goes in at the next edge.
    fetchSeen = fetchSeen | taken;
    lastBusy = {brBusy, memBusy, aluBusy};
  end

  initial begin
    void'($urandom(32'h258e));
    rstN = 1'b0;
    fetchWord = 32'd0;
    fetchValid = 1'b0;
    aluBusy = 1'b0;
    memBusy = 1'b0;
    brBusy = 1'b0;
    buildStream();
    cycleLimit = 40 * expected.size() + 100;
    repeat (2) @(posedge clk);
    #5 rstN = 1'b1;
    repeat (3) @(posedge clk);
    while (expected.size() != 0) begin
      @(posedge clk);
      #5;
      if (taken) begin
        wordIdx++;
      end
      if (!fetchValid || taken) begin
        if (wordIdx < words.size()) begin
          fetchWord = words[wordIdx];
          fetchValid = ($urandom % 4) != 0;
        end else begin
          fetchValid = 1'b0;
        end
      end
      driveBusy();
    end
    if (sawFull && sawHold) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("queue never filled or fetchHold never rose under busy stalls");
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
rtl/predecPkg.sv
rtl/rvPredecoder.sv
rtl/instrAligner.sv
rtl/predecQueue.sv
rtl/dispatchSteer.sv
rtl/predecTop.sv
tests/predecTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; exit status reports pass or fail.

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert \
    -f verilog.f \
    --top-module predecTb \
    -o predecSim &&
  ./obj_dir/predecSim ||
  { echo "simulation failed"; exit 1; }
